/* hw/cdc_bridge_macros.svh */
`ifndef CDC_BRIDGE_MACROS_SVH
`define CDC_BRIDGE_MACROS_SVH

// address bits of one lane, so each lane holds 1 << 4 = 16 words
`define CDC_ADDR_SIZE 4

// number of independent lanes behind the bridge
`define CDC_LANES 4

// width of the lane tag carried with every word
`define CDC_LANE_W 2

// payload width of one stored word
`define CDC_DATA_W 16

// almost-full rises when this many free slots or fewer remain
`define CDC_ALMOST_FULL_BUF 2

`endif

/* hw/cdc_bridge_pkg.sv */
`include "cdc_bridge_macros.svh"

package cdc_bridge_pkg;

  // payload as it sits in a lane's storage
  typedef logic [`CDC_DATA_W-1:0] lane_data_t;

  // word with its lane tag, used on the input and the output
  typedef struct packed {
    logic [`CDC_LANE_W-1:0] lane;
    lane_data_t             data;
  } tagged_word_t;

  // pointers are zero-extended into this width so any depth works
  typedef logic [31:0] gray_vec_t;

  function automatic gray_vec_t bin_to_gray(gray_vec_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the xor of all gray bits at and above it
  function automatic gray_vec_t gray_to_bin(gray_vec_t gray);
    gray_vec_t bin;
    bin[31] = gray[31];
    for (int i = 30; i >= 0; i--) bin[i] = bin[i+1] ^ gray[i];
    return bin;
  endfunction

endpackage

/* hw/cdc_fifo_wptr_full.sv */
`timescale 1ns/1ps

module cdc_fifo_wptr_full import cdc_bridge_pkg::*; #(
  parameter int ADDR_SIZE       = `CDC_ADDR_SIZE,
  parameter int ALMOST_FULL_BUF = `CDC_ALMOST_FULL_BUF
) (
  input  logic                 w_clk,
  input  logic                 w_rst_n,
  input  logic                 w_inc,
  input  logic [ADDR_SIZE:0]   w_q2_rptr,
  output logic                 w_full,
  output logic                 w_almost_full,
  output logic [ADDR_SIZE:0]   w_ptr,
  output logic [ADDR_SIZE-1:0] w_addr
);

  // occupancy at which almost-full is raised
  localparam logic [ADDR_SIZE:0] AF_LEVEL = (ADDR_SIZE+1)'((1 << ADDR_SIZE) - ALMOST_FULL_BUF);

  logic [ADDR_SIZE:0] w_bin;
  logic [ADDR_SIZE:0] w_bin_next;
  logic [ADDR_SIZE:0] w_gray_next;
  logic [ADDR_SIZE:0] w_rbin;
  logic [ADDR_SIZE:0] w_used_next;
  gray_vec_t          w_gray_wide;
  gray_vec_t          w_rbin_wide;

  // storage is addressed with the plain binary pointer
  assign w_addr = w_bin[ADDR_SIZE-1:0];

  // a push on a full lane leaves the pointer where it is
  assign w_bin_next  = w_bin + {{ADDR_SIZE{1'b0}}, w_inc & ~w_full};
  assign w_gray_wide = bin_to_gray(gray_vec_t'(w_bin_next));
  assign w_gray_next = w_gray_wide[ADDR_SIZE:0];

  // the read pointer is only usable for subtraction in binary form
  assign w_rbin_wide = gray_to_bin(gray_vec_t'(w_q2_rptr));
  assign w_rbin      = w_rbin_wide[ADDR_SIZE:0];
  assign w_used_next = w_bin_next - w_rbin;

  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      w_bin         <= '0;
      w_ptr         <= '0;
      w_full        <= 1'b0;
      w_almost_full <= 1'b0;
    end else begin
      w_bin <= w_bin_next;
      w_ptr <= w_gray_next;
      // full when the write side has lapped the read side by one whole depth
      w_full <= (w_gray_next == {~w_q2_rptr[ADDR_SIZE:ADDR_SIZE-1], w_q2_rptr[ADDR_SIZE-2:0]});
      // almost-full is pessimistic since the read pointer lags behind
      w_almost_full <= (w_used_next >= AF_LEVEL);
    end
  end

endmodule

/* hw/cdc_fifo_rptr_empty.sv */
`timescale 1ns/1ps

module cdc_fifo_rptr_empty import cdc_bridge_pkg::*; #(
  parameter int ADDR_SIZE = `CDC_ADDR_SIZE
) (
  input  logic                 r_clk,
  input  logic                 r_rst_n,
  input  logic                 r_inc,
  input  logic [ADDR_SIZE:0]   r_q2_wptr,
  output logic                 r_empty,
  output logic [ADDR_SIZE:0]   r_ptr,
  output logic [ADDR_SIZE-1:0] r_addr
);

  logic [ADDR_SIZE:0] r_bin;
  logic [ADDR_SIZE:0] r_bin_next;
  logic [ADDR_SIZE:0] r_gray_next;
  gray_vec_t          r_gray_wide;

  // the storage read port looks at this address without a clock
  assign r_addr = r_bin[ADDR_SIZE-1:0];

  // popping an empty lane does not move the pointer
  assign r_bin_next  = r_bin + {{ADDR_SIZE{1'b0}}, r_inc & ~r_empty};
  assign r_gray_wide = bin_to_gray(gray_vec_t'(r_bin_next));
  assign r_gray_next = r_gray_wide[ADDR_SIZE:0];

  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      r_bin   <= '0;
      r_ptr   <= '0;
      r_empty <= 1'b1;
    end else begin
      r_bin <= r_bin_next;
      r_ptr <= r_gray_next;
      // empty when the read side has caught up with the synchronized writer
      r_empty <= (r_gray_next == r_q2_wptr);
    end
  end

endmodule

/* hw/cdc_fifo.sv */
`timescale 1ns/1ps

module cdc_fifo #(
  parameter int ADDR_SIZE       = `CDC_ADDR_SIZE,
  parameter int DATA_W          = `CDC_DATA_W,
  parameter int ALMOST_FULL_BUF = `CDC_ALMOST_FULL_BUF
) (
  input  logic              w_clk,
  input  logic              w_rst_n,
  input  logic              w_inc,
  input  logic [DATA_W-1:0] w_data,
  output logic              w_full,
  output logic              w_almost_full,
  input  logic              r_clk,
  input  logic              r_rst_n,
  input  logic              r_inc,
  output logic [DATA_W-1:0] r_data,
  output logic              r_empty
);

  localparam int DEPTH = 1 << ADDR_SIZE;

  logic [DATA_W-1:0]    mem [DEPTH];
  logic [ADDR_SIZE-1:0] w_addr;
  logic [ADDR_SIZE-1:0] r_addr;
  logic [ADDR_SIZE:0]   w_ptr;
  logic [ADDR_SIZE:0]   r_ptr;
  logic [ADDR_SIZE:0]   r_q1_wptr;
  logic [ADDR_SIZE:0]   r_q2_wptr;
  logic [ADDR_SIZE:0]   w_q1_rptr;
  logic [ADDR_SIZE:0]   w_q2_rptr;

  // only accepted pushes reach the array
  always_ff @(posedge w_clk) begin
    if (w_inc && !w_full) mem[w_addr] <= w_data;
  end

  // asynchronous read so the word is ready in the same cycle as the pop
  assign r_data = mem[r_addr];

  // gray write pointer into the read domain, one bit changes per step
  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      r_q1_wptr <= '0;
      r_q2_wptr <= '0;
    end else begin
      r_q1_wptr <= w_ptr;
      r_q2_wptr <= r_q1_wptr;
    end
  end

  // gray read pointer into the write domain
  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      w_q1_rptr <= '0;
      w_q2_rptr <= '0;
    end else begin
      w_q1_rptr <= r_ptr;
      w_q2_rptr <= w_q1_rptr;
    end
  end

  cdc_fifo_wptr_full #(
    .ADDR_SIZE       (ADDR_SIZE),
    .ALMOST_FULL_BUF (ALMOST_FULL_BUF)
  ) wptr_full_i (
    .w_clk         (w_clk),
    .w_rst_n       (w_rst_n),
    .w_inc         (w_inc),
    .w_q2_rptr     (w_q2_rptr),
    .w_full        (w_full),
    .w_almost_full (w_almost_full),
    .w_ptr         (w_ptr),
    .w_addr        (w_addr)
  );

  cdc_fifo_rptr_empty #(
    .ADDR_SIZE (ADDR_SIZE)
  ) rptr_empty_i (
    .r_clk     (r_clk),
    .r_rst_n   (r_rst_n),
    .r_inc     (r_inc),
    .r_q2_wptr (r_q2_wptr),
    .r_empty   (r_empty),
    .r_ptr     (r_ptr),
    .r_addr    (r_addr)
  );

endmodule

/* hw/lane_steer.sv */
`timescale 1ns/1ps

module lane_steer import cdc_bridge_pkg::*; #(
  parameter int LANES = `CDC_LANES
) (
  input  logic             in_valid,
  input  tagged_word_t     in_word,
  output logic [LANES-1:0] lane_push,
  output lane_data_t       lane_wdata
);

  localparam int TAG_W = `CDC_LANE_W;

  // every lane sees the payload, only the tagged one gets the strobe
  assign lane_wdata = in_word.data;

  // pure decode with no register, so push and data arrive together
  // and the lane's own full flag is the one place a push is refused
  always_comb begin
    lane_push = '0;
    for (int i = 0; i < LANES; i++) begin
      // a tag naming no existing lane matches nothing and is dropped
      lane_push[i] = in_valid && (in_word.lane == TAG_W'(i));
    end
  end

endmodule

/* hw/lane_drain_arb.sv */
`timescale 1ns/1ps

module lane_drain_arb import cdc_bridge_pkg::*; #(
  parameter int LANES = `CDC_LANES
) (
  input  logic             r_clk,
  input  logic             r_rst_n,
  input  logic             r_en,
  input  logic [LANES-1:0] lane_empty,
  input  lane_data_t       lane_rdata [LANES],
  output logic [LANES-1:0] lane_pop,
  output logic             out_valid,
  output tagged_word_t     out_word
);

  localparam int TAG_W = `CDC_LANE_W;

  logic [TAG_W-1:0] last_q;
  logic [TAG_W-1:0] grant_idx;
  logic             found;

  // search starts just after the last served lane and wraps around,
  // so the last served lane itself is checked last
  always_comb begin
    found     = 1'b0;
    grant_idx = last_q;
    for (int k = 1; k <= LANES; k++) begin
      if (!found && !lane_empty[(int'(last_q) + k) % LANES]) begin
        found     = 1'b1;
        grant_idx = TAG_W'((int'(last_q) + k) % LANES);
      end
    end
  end

  // one pop per cycle at most, and none while r_en is low
  always_comb begin
    lane_pop = '0;
    if (r_en && found) lane_pop[grant_idx] = 1'b1;
  end

  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      out_valid <= 1'b0;
      last_q    <= TAG_W'(LANES - 1);
    end else begin
      out_valid <= r_en && found;
      // the pointer only moves when a lane was actually served
      if (r_en && found) last_q <= grant_idx;
    end
  end

  // the popped word is captured on the same edge that advances the lane
  always_ff @(posedge r_clk) begin
    if (r_en && found) begin
      out_word.lane <= grant_idx;
      out_word.data <= lane_rdata[grant_idx];
    end
  end

endmodule

/* hw/cdc_bridge_top.sv */
`timescale 1ns/1ps

module cdc_bridge_top import cdc_bridge_pkg::*; #(
  parameter int LANES = `CDC_LANES
) (
  input  logic             w_clk,
  input  logic             w_rst_n,
  input  logic             in_valid,
  input  tagged_word_t     in_word,
  output logic [LANES-1:0] full,
  output logic [LANES-1:0] almost_full,
  input  logic             r_clk,
  input  logic             r_rst_n,
  input  logic             r_en,
  output logic             out_valid,
  output tagged_word_t     out_word
);

  logic [LANES-1:0] lane_push;
  lane_data_t       lane_wdata;
  logic [LANES-1:0] lane_pop;
  logic [LANES-1:0] lane_empty;
  lane_data_t       lane_rdata [LANES];

  // write side decode of the tag into one push strobe
  lane_steer #(
    .LANES (LANES)
  ) steer_i (
    .in_valid   (in_valid),
    .in_word    (in_word),
    .lane_push  (lane_push),
    .lane_wdata (lane_wdata)
  );

  // one asynchronous FIFO per lane, each with its own flags
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    cdc_fifo lane_i (
      .w_clk         (w_clk),
      .w_rst_n       (w_rst_n),
      .w_inc         (lane_push[i]),
      .w_data        (lane_wdata),
      .w_full        (full[i]),
      .w_almost_full (almost_full[i]),
      .r_clk         (r_clk),
      .r_rst_n       (r_rst_n),
      .r_inc         (lane_pop[i]),
      .r_data        (lane_rdata[i]),
      .r_empty       (lane_empty[i])
    );
  end

  // read side merges the lanes back onto one tagged output
  lane_drain_arb #(
    .LANES (LANES)
  ) drain_i (
    .r_clk      (r_clk),
    .r_rst_n    (r_rst_n),
    .r_en       (r_en),
    .lane_empty (lane_empty),
    .lane_rdata (lane_rdata),
    .lane_pop   (lane_pop),
    .out_valid  (out_valid),
    .out_word   (out_word)
  );

endmodule

/* dv/cdc_bridge_checker.sv */
`timescale 1ns/1ps
`include "cdc_bridge_macros.svh"

module cdc_bridge_checker import cdc_bridge_pkg::*; #(
  parameter int LANES = `CDC_LANES
) (
  input logic             w_clk,
  input logic             w_rst_n,
  input logic             r_clk,
  input logic             r_rst_n,
  input logic [LANES-1:0] full,
  input logic [LANES-1:0] almost_full,
  input logic             out_valid,
  input tagged_word_t     out_word
);

  // number of assertion failures seen so far
  int assert_fails = 0;

  // the output register is cleared by the reset edge itself, so look one cycle on
  a_no_valid_in_reset: assert property (@(posedge r_clk) !r_rst_n |=> !out_valid)
    else begin
      $error("out_valid high while the read side is held in reset");
      assert_fails++;
    end

  // a lane with no free slot has certainly passed the almost-full level
  a_full_has_af: assert property (@(posedge w_clk) disable iff (!w_rst_n)
    (full & ~almost_full) == '0)
    else begin
      $error("full is set on a lane whose almost_full is clear");
      assert_fails++;
    end

  // a popped word always comes from a slot that was written
  a_word_known: assert property (@(posedge r_clk) disable iff (!r_rst_n)
    out_valid |-> !$isunknown(out_word))
    else begin
      $error("out_word carries unknown bits while out_valid is high");
      assert_fails++;
    end

endmodule

bind cdc_bridge_top cdc_bridge_checker #(.LANES(LANES)) checker_i (
  .w_clk       (w_clk),
  .w_rst_n     (w_rst_n),
  .r_clk       (r_clk),
  .r_rst_n     (r_rst_n),
  .full        (full),
  .almost_full (almost_full),
  .out_valid   (out_valid),
  .out_word    (out_word)
);

/* dv/cdc_bridge_tb.sv */
`timescale 1ns/1ps
`include "cdc_bridge_macros.svh"

module cdc_bridge_tb import cdc_bridge_pkg::*; ();

  localparam int LANES    = `CDC_LANES;
  localparam int TAG_W    = `CDC_LANE_W;
  localparam int DEPTH    = 1 << `CDC_ADDR_SIZE;
  localparam int AF_LEVEL = DEPTH - `CDC_ALMOST_FULL_BUF;
  // random pushes stay well below full because the write side learns of reads late
  localparam int RAND_LIMIT   = DEPTH - 6;
  localparam int N_RANDOM     = 300;
  localparam int N_EXTRA      = 3;
  localparam int N_OTHER      = 4;
  localparam int TOTAL_PUSHES = N_RANDOM + DEPTH + N_EXTRA + (LANES - 1) * N_OTHER;
  localparam int TIMEOUT_NS   = TOTAL_PUSHES * 40 + 4000;

  logic             w_clk    = 1'b0;
  logic             r_clk    = 1'b1;
  logic             w_rst_n  = 1'b0;
  logic             r_rst_n  = 1'b0;
  logic             in_valid = 1'b0;
  tagged_word_t     in_word  = '0;
  logic             r_en     = 1'b0;
  logic [LANES-1:0] full;
  logic [LANES-1:0] almost_full;
  logic             out_valid;
  tagged_word_t     out_word;

  logic [31:0] lfsr = 32'he9b75096;
  // 0 holds r_en low, 1 toggles it at random, 2 holds it high
  int          r_mode    = 0;
  string       test_name = "reset";
  // words that each lane is expected to deliver, oldest first
  lane_data_t  ref_q [LANES][$];

  always #2 w_clk = ~w_clk;
  // starting high keeps its falling edges apart from those of w_clk
  always #3 r_clk = ~r_clk;

  cdc_bridge_top cdc_bridge_top_i (
    .w_clk       (w_clk),
    .w_rst_n     (w_rst_n),
    .in_valid    (in_valid),
    .in_word     (in_word),
    .full        (full),
    .almost_full (almost_full),
    .r_clk       (r_clk),
    .r_rst_n     (r_rst_n),
    .r_en        (r_en),
    .out_valid   (out_valid),
    .out_word    (out_word)
  );

  // taps 32, 22, 2 and 1 give a maximal length sequence
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  // the word a lane must deliver next, with its own tag
  function automatic tagged_word_t expected_word(logic [TAG_W-1:0] lane);
    tagged_word_t w;
    w.lane = lane;
    w.data = ref_q[lane][0];
    return w;
  endfunction

  function automatic int pending_words();
    int total;
    total = 0;
    for (int l = 0; l < LANES; l++) total += ref_q[l].size();
    return total;
  endfunction

  task automatic stop_on_failure();
    $display("sim failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  // with reads settled, the flags follow directly from each lane's occupancy
  task automatic check_flags();
    logic [LANES-1:0] exp_full;
    logic [LANES-1:0] exp_af;
    for (int l = 0; l < LANES; l++) begin
      exp_full[l] = ref_q[l].size() >= DEPTH;
      exp_af[l]   = ref_q[l].size() >= AF_LEVEL;
    end
    check_value({test_name, " full"}, 32'(exp_full), 32'(full));
    check_value({test_name, " almost_full"}, 32'(exp_af), 32'(almost_full));
  endtask

  // called on a falling edge, holds the word for one w_clk cycle
  task automatic push_word(input logic [TAG_W-1:0] lane, input lane_data_t data);
    in_word.lane = lane;
    in_word.data = data;
    in_valid     = 1'b1;
    // a word sent to a lane with no free slot is dropped by the bridge
    if (ref_q[lane].size() < DEPTH) ref_q[lane].push_back(data);
    @(negedge w_clk);
    in_valid = 1'b0;
  endtask

  task automatic drain_all();
    r_mode = 2;
    while (pending_words() != 0) @(negedge w_clk);
    r_mode = 0;
    // let the last read pointers cross back into the write domain
    repeat (10) @(negedge w_clk);
  endtask

  always @(negedge r_clk) begin : drive_r_en
    logic [31:0] bits;
    case (r_mode)
      1: begin
        take_bits(1, bits);
        r_en = bits[0];
      end
      2: r_en = 1'b1;
      default: r_en = 1'b0;
    endcase
  end

  // every output word must be the oldest word still owed by its lane
  always @(negedge r_clk) begin
    if (r_rst_n && out_valid) begin
      if (ref_q[out_word.lane].size() == 0) begin
        $display("output word on lane %0d arrived with no word pending there",
                 out_word.lane);
        stop_on_failure();
      end
      check_value(test_name, 32'(expected_word(out_word.lane)), 32'(out_word));
      void'(ref_q[out_word.lane].pop_front());
    end
  end

  // a failed assertion in the bound checker ends the run right away
  always @(cdc_bridge_top_i.checker_i.assert_fails) begin
    if (cdc_bridge_top_i.checker_i.assert_fails != 0) begin
      $display("an assertion in the checker failed during %s", test_name);
      stop_on_failure();
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns with %0d words still pending", TIMEOUT_NS,
             pending_words());
    stop_on_failure();
  end

  initial begin
    logic [31:0]      go;
    logic [31:0]      lane;
    logic [31:0]      data;
    logic [TAG_W-1:0] full_lane;
    fork
      begin
        repeat (8) @(posedge w_clk);
        @(negedge w_clk);
        w_rst_n = 1'b1;
      end
      begin
        repeat (8) @(posedge r_clk);
        @(negedge r_clk);
        r_rst_n = 1'b1;
      end
    join
    repeat (4) begin
      @(negedge w_clk);
      check_flags();
    end

    test_name = "integrity";
    r_mode    = 1;
    for (int i = 0; i < N_RANDOM; i++) begin
      take_bits(1, go);
      take_bits(TAG_W, lane);
      take_bits(16, data);
      if (go[0] && ref_q[lane[TAG_W-1:0]].size() < RAND_LIMIT) begin
        push_word(lane[TAG_W-1:0], data[15:0]);
      end else begin
        @(negedge w_clk);
      end
    end
    drain_all();

    // fill one lane past its depth with the read side stopped
    test_name = "full_drop";
    take_bits(TAG_W, lane);
    full_lane = lane[TAG_W-1:0];
    for (int i = 0; i < DEPTH + N_EXTRA; i++) begin
      take_bits(16, data);
      push_word(full_lane, data[15:0]);
      check_flags();
    end

    test_name = "isolation";
    for (int l = 0; l < LANES; l++) begin
      if (l != int'(full_lane)) begin
        for (int n = 0; n < N_OTHER; n++) begin
          take_bits(16, data);
          push_word(TAG_W'(l), data[15:0]);
          check_flags();
        end
      end
    end
    drain_all();
    check_flags();

    $display("sim passed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+hw
hw/cdc_bridge_pkg.sv
hw/cdc_fifo_wptr_full.sv
hw/cdc_fifo_rptr_empty.sv
hw/cdc_fifo.sv
hw/lane_steer.sv
hw/lane_drain_arb.sv
hw/cdc_bridge_top.sv
dv/cdc_bridge_checker.sv
dv/cdc_bridge_tb.sv
